// ==== tlul_params.svh ====
`ifndef TLUL_PARAMS_SVH
`define TLUL_PARAMS_SVH

// Widths of the TL-UL A and D channels

// Byte address width on the bus
`define TL_AW 32

// Bus data width in bits
`define TL_DW 32

// Bytes per bus word, one mask bit each
`define TL_DBW 4

// Source id width, echoed back on the D channel
`define TL_AIW 8

// Size field width, log2 of the byte count
`define TL_SZW 2

// SRAM geometry, 256 words of 64 bits
`define SRAM_AW 8
`define SRAM_DW 64

// Default number of requests in flight before a_ready drops
`define OUTSTANDING_DEF 2

`endif

// ==== tlul_pkg.sv ====
`include "tlul_params.svh"

package tlul_pkg;

  // A-channel opcodes as carried on a_opcode
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D-channel opcodes, data is only valid with AccessAckData
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Number of bits needed to index a value, at least one
  function automatic int vbits(int value);
    return (value == 1) ? 1 : $clog2(value);
  endfunction

  // The size field encodes log2 of the bytes moved by a beat
  function automatic int unsigned size_bytes(logic [`TL_SZW-1:0] size);
    return 1 << size;
  endfunction

endpackage

// ==== sram_pkg.sv ====
`include "tlul_params.svh"

package sram_pkg;

  // Kind of request held while its response is pending
  typedef enum logic [1:0] {
    OpWrite,
    OpRead,
    OpUnknown
  } req_op_e;

  // Everything the D channel needs except the read data
  typedef struct packed {
    req_op_e             op;
    logic                error;
    logic [`TL_SZW-1:0]  size;
    logic [`TL_AIW-1:0]  source;
  } req_entry_t;

  // Byte lanes and SRAM half of an outstanding read
  typedef struct packed {
    logic [`TL_DBW-1:0] mask;
    logic               woffset;
  } sram_req_t;

  // Read data already narrowed to the bus word
  typedef struct packed {
    logic [`TL_DW-1:0] data;
    logic              error;
  } rsp_entry_t;

endpackage

// ==== fifo_sync.sv ====
`timescale 1ns/1ps

module fifo_sync #(
  parameter int Width = 16,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0
) (
  input  logic             clock,
  input  logic             rst_n_i,
  input  logic             clr_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrW-1:0]  wptr;
  logic [PtrW-1:0]  rptr;
  logic [CntW-1:0]  count;
  logic             empty;
  logic             full;
  logic             pass_now;
  logic             push;
  logic             pop;

  assign empty = (count == '0);
  assign full  = (count == CntW'(Depth));

  // In pass mode a write into an empty FIFO is visible at the read side at once
  assign pass_now = Pass && empty && wvalid_i;

  assign wready_o = ~full;
  assign rvalid_o = ~empty | pass_now;
  assign rdata_o  = pass_now ? wdata_i : mem[rptr];

  // A word taken straight through in the same cycle is never stored
  assign push = wvalid_i & ~full & ~(pass_now & rready_i);
  assign pop  = rready_i & ~empty;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clr_i) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == PtrW'(Depth - 1)) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == PtrW'(Depth - 1)) ? '0 : rptr + 1'b1;
      end
      // Simultaneous push and pop leave the fill level unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clock) begin
    if (push) begin
      mem[wptr] <= wdata_i;
    end
  end

endmodule

// ==== tlul_err.sv ====
`timescale 1ns/1ps
`include "tlul_params.svh"

module tlul_err import tlul_pkg::*; (
  input  logic                a_valid_i,
  input  logic [2:0]          a_opcode_i,
  input  logic [`TL_SZW-1:0]  a_size_i,
  input  logic [`TL_AW-1:0]   a_address_i,
  input  logic [`TL_DBW-1:0]  a_mask_i,
  output logic                err_o
);

  localparam int LsbW = vbits(`TL_DBW);

  logic [LsbW-1:0]    lsb;
  logic [`TL_DBW-1:0] size_mask;
  logic               op_ok;
  logic               size_ok;
  logic               addr_ok;
  logic               mask_ok;

  // Only the byte offset inside the bus word matters here
  assign lsb = a_address_i[LsbW-1:0];

  assign op_ok   = a_opcode_i inside {Get, PutFullData, PutPartialData};
  assign size_ok = (a_size_i <= `TL_SZW'(2));

  // The address has to be a multiple of the transfer size
  assign addr_ok = ((int'(lsb) & (size_bytes(a_size_i) - 1)) == 0);

  // A byte lane belongs to the beat when it sits in the same size-aligned chunk
  always_comb begin
    for (int i = 0; i < `TL_DBW; i++) begin
      size_mask[i] = ((i >> a_size_i) == (int'(lsb) >> a_size_i));
    end
  end

  // Partial writes may drop lanes, full writes and reads must cover all of them
  always_comb begin
    case (a_opcode_i)
      PutPartialData: mask_ok = ((a_mask_i & ~size_mask) == '0);
      default:        mask_ok = (a_mask_i == size_mask);
    endcase
  end

  assign err_o = a_valid_i & ~(op_ok & size_ok & addr_ok & mask_ok);

endmodule

// ==== tlul_sram_adapter.sv ====
`timescale 1ns/1ps
`include "tlul_params.svh"

module tlul_sram_adapter import tlul_pkg::*, sram_pkg::*; #(
  parameter int Outstanding = `OUTSTANDING_DEF,
  parameter bit ByteAccess  = 1'b1
) (
  input  logic                 clock,
  input  logic                 rst_n_i,
  // A channel
  input  logic                 a_valid_i,
  input  logic [2:0]           a_opcode_i,
  input  logic [`TL_SZW-1:0]   a_size_i,
  input  logic [`TL_AIW-1:0]   a_source_i,
  input  logic [`TL_AW-1:0]    a_address_i,
  input  logic [`TL_DBW-1:0]   a_mask_i,
  input  logic [`TL_DW-1:0]    a_data_i,
  output logic                 a_ready_o,
  // D channel
  output logic                 d_valid_o,
  output tl_d_op_e             d_opcode_o,
  output logic [`TL_SZW-1:0]   d_size_o,
  output logic [`TL_AIW-1:0]   d_source_o,
  output logic [`TL_DW-1:0]    d_data_o,
  output logic                 d_error_o,
  input  logic                 d_ready_i,
  // SRAM side
  output logic                 req_o,
  input  logic                 gnt_i,
  output logic                 we_o,
  output logic [`SRAM_AW-1:0]  addr_o,
  output logic [`SRAM_DW-1:0]  wdata_o,
  output logic [`SRAM_DW-1:0]  wmask_o,
  input  logic [`SRAM_DW-1:0]  rdata_i,
  input  logic                 rvalid_i,
  input  logic [1:0]           rerror_i
);

  localparam int WordLsb   = vbits(`TL_DBW);
  localparam int SramLsb   = vbits(`SRAM_DW / 8);
  localparam int WidthMult = `SRAM_DW / `TL_DW;

  logic       a_ack;
  logic       d_ack;
  logic       sram_ack;
  logic       is_write;
  logic       tlul_error;
  logic       wr_attr_error;
  logic       error_internal;
  logic       woffset;
  logic       d_valid;
  logic       d_err;

  logic       reqfifo_wready;
  logic       reqfifo_rvalid;
  req_entry_t reqfifo_wdata;
  req_entry_t reqfifo_rdata;
  logic       sramreqfifo_wvalid;
  logic       sramreqfifo_wready;
  sram_req_t  sramreqfifo_wdata;
  sram_req_t  sramreqfifo_rdata;
  logic       rspfifo_rvalid;
  logic       rspfifo_rready;
  rsp_entry_t rspfifo_wdata;
  rsp_entry_t rspfifo_rdata;

  logic [WidthMult-1:0][`TL_DW-1:0] wmask_int;
  logic [WidthMult-1:0][`TL_DW-1:0] wdata_int;
  logic [WidthMult-1:0][`TL_DW-1:0] rdata_split;
  logic [`TL_DW-1:0]                rdata_word;

  assign a_ack    = a_valid_i & a_ready_o;
  assign d_ack    = d_valid_o & d_ready_i;
  assign sram_ack = req_o & gnt_i;

  assign is_write = a_opcode_i inside {PutFullData, PutPartialData};

  // Protocol checks live in tlul_err, only the partial-write rule is local
  tlul_err u_err (
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .err_o       (tlul_error)
  );

  assign wr_attr_error = is_write & ~ByteAccess &
                         ((a_mask_i != '1) | (a_size_i != `TL_SZW'(2)));
  assign error_internal = tlul_error | wr_attr_error;

  // An errored request is accepted without waiting for the SRAM grant
  assign a_ready_o = (gnt_i | error_internal) & reqfifo_wready & sramreqfifo_wready;

  // Bad requests never reach the SRAM and get their error answer from the request FIFO
  assign req_o  = a_valid_i & reqfifo_wready & sramreqfifo_wready & ~error_internal;
  assign we_o   = a_valid_i & is_write;
  assign addr_o = a_address_i[SramLsb +: `SRAM_AW];

  // Address bit 2 picks which half of the 64-bit word the bus word maps to
  assign woffset = a_address_i[SramLsb-1:WordLsb];

  // Spread the byte mask into a bit mask and place data in the selected half
  always_comb begin
    wmask_int = '0;
    wdata_int = '0;
    for (int i = 0; i < `TL_DBW; i++) begin
      wmask_int[woffset][8*i +: 8] = {8{a_mask_i[i]}};
      wdata_int[woffset][8*i +: 8] = a_mask_i[i] ? a_data_i[8*i +: 8] : 8'h00;
    end
  end

  assign wmask_o = wmask_int;
  assign wdata_o = wdata_int;

  // Every accepted request is logged so that responses leave in order
  always_comb begin
    reqfifo_wdata.error  = error_internal;
    reqfifo_wdata.size   = a_size_i;
    reqfifo_wdata.source = a_source_i;
    if (a_opcode_i == Get) begin
      reqfifo_wdata.op = OpRead;
    end else if (is_write) begin
      reqfifo_wdata.op = OpWrite;
    end else begin
      reqfifo_wdata.op = OpUnknown;
    end
  end

  // Reads also remember their lanes until the SRAM returns data
  assign sramreqfifo_wvalid      = sram_ack & ~we_o;
  assign sramreqfifo_wdata.mask  = a_mask_i;
  assign sramreqfifo_wdata.woffset = woffset;

  // Narrow the SRAM word to the requested half and zero the unrequested lanes
  assign rdata_split = rdata_i;

  always_comb begin
    for (int i = 0; i < `TL_DBW; i++) begin
      rdata_word[8*i +: 8] = sramreqfifo_rdata.mask[i] ?
                             rdata_split[sramreqfifo_rdata.woffset][8*i +: 8] : 8'h00;
    end
  end

  // Bit 1 flags an uncorrectable error, the correctable bit is not reported
  assign rspfifo_wdata.data  = rdata_word;
  assign rspfifo_wdata.error = rerror_i[1];

  // Writes and errored requests answer at once, a clean read waits for its data
  always_comb begin
    d_valid = 1'b0;
    d_err   = 1'b0;
    if (reqfifo_rvalid) begin
      if (reqfifo_rdata.error) begin
        d_valid = 1'b1;
        d_err   = 1'b1;
      end else if (reqfifo_rdata.op == OpRead) begin
        d_valid = rspfifo_rvalid;
        d_err   = rspfifo_rdata.error;
      end else begin
        d_valid = 1'b1;
      end
    end
  end

  assign d_valid_o  = d_valid;
  assign d_error_o  = d_valid & d_err;
  assign d_opcode_o = (d_valid && reqfifo_rdata.op == OpRead) ? AccessAckData : AccessAck;
  assign d_size_o   = d_valid ? reqfifo_rdata.size : '0;
  assign d_source_o = d_valid ? reqfifo_rdata.source : '0;
  assign d_data_o   = (d_valid && reqfifo_rdata.op == OpRead && !reqfifo_rdata.error) ?
                      rspfifo_rdata.data : '0;

  // Only a clean read consumes an entry of the response FIFO
  assign rspfifo_rready = (reqfifo_rdata.op == OpRead) & ~reqfifo_rdata.error & d_ack;

  fifo_sync #(
    .Width (($bits(req_entry_t))),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_reqfifo (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .clr_i    (1'b0),
    .wvalid_i (a_ack),
    .wready_o (reqfifo_wready),
    .wdata_i  (reqfifo_wdata),
    .rvalid_o (reqfifo_rvalid),
    .rready_i (d_ack),
    .rdata_o  (reqfifo_rdata)
  );

  // Popped when the read data comes back, which always matches the oldest read
  fifo_sync #(
    .Width (($bits(sram_req_t))),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_sramreqfifo (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .clr_i    (1'b0),
    .wvalid_i (sramreqfifo_wvalid),
    .wready_o (sramreqfifo_wready),
    .wdata_i  (sramreqfifo_wdata),
    .rvalid_o (),
    .rready_i (rvalid_i),
    .rdata_o  (sramreqfifo_rdata)
  );

  // The SRAM cannot stall read data, so it is caught here while D is back-pressured
  fifo_sync #(
    .Width (($bits(rsp_entry_t))),
    .Depth (Outstanding),
    .Pass  (1'b1)
  ) u_rspfifo (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .clr_i    (1'b0),
    .wvalid_i (rvalid_i),
    .wready_o (),
    .wdata_i  (rspfifo_wdata),
    .rvalid_o (rspfifo_rvalid),
    .rready_i (rspfifo_rready),
    .rdata_o  (rspfifo_rdata)
  );

endmodule

// ==== sram_mem.sv ====
`timescale 1ns/1ps
`include "tlul_params.svh"

module sram_mem import sram_pkg::*; (
  input  logic                clock,
  input  logic                rst_n_i,
  input  logic                req_i,
  output logic                gnt_o,
  input  logic                we_i,
  input  logic [`SRAM_AW-1:0] addr_i,
  input  logic [`SRAM_DW-1:0] wdata_i,
  input  logic [`SRAM_DW-1:0] wmask_i,
  output logic [`SRAM_DW-1:0] rdata_o,
  output logic                rvalid_o,
  output logic [1:0]          rerror_o
);

  localparam int Words = 1 << `SRAM_AW;

  logic [`SRAM_DW-1:0] mem [Words];
  logic [Words-1:0]    written;
  logic [`SRAM_DW-1:0] rdata_q;
  logic                rd_err_q;
  logic                access;
  // What the array did on the previous cycle, OpUnknown when idle
  req_op_e             last_op;

  // A write spends the next cycle on its read-modify-write, so no grant then
  assign gnt_o  = (last_op != OpWrite);
  assign access = req_i & gnt_o;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_op  <= OpUnknown;
      written  <= '0;
      rd_err_q <= 1'b0;
    end else begin
      if (access) begin
        last_op <= we_i ? OpWrite : OpRead;
      end else begin
        last_op <= OpUnknown;
      end
      if (access && we_i) begin
        written[addr_i] <= 1'b1;
      end
      // A word never written holds no valid check bits and reads as broken
      if (access && !we_i) begin
        rd_err_q <= ~written[addr_i];
      end
    end
  end

  // Array and read register
  always_ff @(posedge clock) begin
    if (access && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
    if (access && !we_i) begin
      rdata_q <= written[addr_i] ? mem[addr_i] : '0;
    end
  end

  assign rvalid_o = (last_op == OpRead);
  assign rdata_o  = rdata_q;
  // Bit 1 is uncorrectable, this model never reports a corrected error
  assign rerror_o = {rd_err_q, 1'b0};

endmodule

// ==== tlul_sram_top.sv ====
`timescale 1ns/1ps
`include "tlul_params.svh"

module tlul_sram_top import tlul_pkg::*; (
  input  logic                clock,
  input  logic                rst_n_i,
  // A channel
  input  logic                a_valid_i,
  input  logic [2:0]          a_opcode_i,
  input  logic [`TL_SZW-1:0]  a_size_i,
  input  logic [`TL_AIW-1:0]  a_source_i,
  input  logic [`TL_AW-1:0]   a_address_i,
  input  logic [`TL_DBW-1:0]  a_mask_i,
  input  logic [`TL_DW-1:0]   a_data_i,
  output logic                a_ready_o,
  // D channel
  output logic                d_valid_o,
  output tl_d_op_e            d_opcode_o,
  output logic [`TL_SZW-1:0]  d_size_o,
  output logic [`TL_AIW-1:0]  d_source_o,
  output logic [`TL_DW-1:0]   d_data_o,
  output logic                d_error_o,
  input  logic                d_ready_i
);

  // SRAM strobes between the adapter and the array
  logic                req;
  logic                gnt;
  logic                we;
  logic [`SRAM_AW-1:0] addr;
  logic [`SRAM_DW-1:0] wdata;
  logic [`SRAM_DW-1:0] wmask;
  logic [`SRAM_DW-1:0] rdata;
  logic                rvalid;
  logic [1:0]          rerror;

  tlul_sram_adapter #(
    .Outstanding (`OUTSTANDING_DEF),
    .ByteAccess  (1'b1)
  ) u_adapter (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .a_ready_o   (a_ready_o),
    .d_valid_o   (d_valid_o),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o),
    .d_ready_i   (d_ready_i),
    .req_o       (req),
    .gnt_i       (gnt),
    .we_o        (we),
    .addr_o      (addr),
    .wdata_o     (wdata),
    .wmask_o     (wmask),
    .rdata_i     (rdata),
    .rvalid_i    (rvalid),
    .rerror_i    (rerror)
  );

  sram_mem u_sram (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .req_i    (req),
    .gnt_o    (gnt),
    .we_i     (we),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .wmask_i  (wmask),
    .rdata_o  (rdata),
    .rvalid_o (rvalid),
    .rerror_o (rerror)
  );

endmodule

// ==== tb_tlul_sram.sv ====
`timescale 1ns/1ps
`include "tlul_params.svh"

module tb_tlul_sram import tlul_pkg::*; ();

  // Worst case is about 100 requests of up to 6 cycles each plus random stalls on D
  localparam int CYCLE_LIMIT = 2000;

  typedef struct packed {
    logic [2:0]          op;
    logic [`TL_SZW-1:0]  size;
    logic [`TL_AIW-1:0]  source;
    logic [`TL_DW-1:0]   data;
    logic                error;
  } exp_rsp_t;

  logic                clock;
  logic                rst_n_i;
  logic                a_valid_i;
  logic [2:0]          a_opcode_i;
  logic [`TL_SZW-1:0]  a_size_i;
  logic [`TL_AIW-1:0]  a_source_i;
  logic [`TL_AW-1:0]   a_address_i;
  logic [`TL_DBW-1:0]  a_mask_i;
  logic [`TL_DW-1:0]   a_data_i;
  logic                a_ready_o;
  logic                d_valid_o;
  tl_d_op_e            d_opcode_o;
  logic [`TL_SZW-1:0]  d_size_o;
  logic [`TL_AIW-1:0]  d_source_o;
  logic [`TL_DW-1:0]   d_data_o;
  logic                d_error_o;
  logic                d_ready_i;

  // Reference memory, one written flag per 64-bit word
  bit [`SRAM_DW-1:0]   ref_mem [1 << `SRAM_AW];
  bit                  ref_written [1 << `SRAM_AW];
  exp_rsp_t            exp_q [$];
  exp_rsp_t            head;
  int                  pending;
  int                  mismatches;
  int                  other_errors;
  int                  cycles;
  logic [31:0]         lfsr;
  logic [`TL_AIW-1:0]  source_id;
  bit                  random_ready;
  bit                  a_taken;
  bit                  d_taken;

  tlul_sram_top dut0 (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .a_ready_o   (a_ready_o),
    .d_valid_o   (d_valid_o),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o),
    .d_ready_i   (d_ready_i)
  );

  always #50 clock = ~clock;

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit handed out
  function automatic logic [31:0] rand_bits(int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // Byte lanes that a beat of 2**size bytes starting at this offset touches
  function automatic logic [`TL_DBW-1:0] covered_lanes(int offset, int size);
    logic [`TL_DBW-1:0] lanes;
    for (int i = 0; i < `TL_DBW; i++) begin
      lanes[i] = (i >= offset) && (i < offset + (1 << size));
    end
    return lanes;
  endfunction

  function automatic bit request_error(logic [2:0] op, logic [`TL_SZW-1:0] size,
                                       logic [`TL_AW-1:0] addr, logic [`TL_DBW-1:0] mask);
    logic [`TL_DBW-1:0] lanes;
    if (!(op == Get || op == PutFullData || op == PutPartialData)) begin
      return 1'b1;
    end
    if (size > 2'd2) begin
      return 1'b1;
    end
    if ((int'(addr[1:0]) % (1 << int'(size))) != 0) begin
      return 1'b1;
    end
    lanes = covered_lanes(int'(addr[1:0]), int'(size));
    // Partial writes may leave lanes out but never add lanes outside the beat
    if (op == PutPartialData) begin
      return (mask & ~lanes) != 4'b0;
    end
    return mask != lanes;
  endfunction

  // Expected answer for one accepted request, clean writes also land in the model
  function automatic exp_rsp_t model_request(logic [2:0] op, logic [`TL_SZW-1:0] size,
                                             logic [`TL_AIW-1:0] source,
                                             logic [`TL_AW-1:0] addr,
                                             logic [`TL_DBW-1:0] mask,
                                             logic [`TL_DW-1:0] data);
    exp_rsp_t rsp;
    int       word;
    int       half;
    // Bits 10:3 pick the SRAM word and bit 2 the 32-bit half inside it
    word       = int'(addr[10:3]);
    half       = int'(addr[2]);
    rsp.op     = (op == Get) ? AccessAckData : AccessAck;
    rsp.size   = size;
    rsp.source = source;
    rsp.data   = '0;
    rsp.error  = request_error(op, size, addr, mask);
    if (!rsp.error && op == Get) begin
      // An unwritten word reads as zero with an uncorrectable error
      rsp.error = !ref_written[word];
      for (int i = 0; i < `TL_DBW; i++) begin
        if (mask[i] && ref_written[word]) begin
          rsp.data[8*i +: 8] = ref_mem[word][32*half + 8*i +: 8];
        end
      end
    end else if (!rsp.error) begin
      ref_written[word] = 1'b1;
      for (int i = 0; i < `TL_DBW; i++) begin
        if (mask[i]) begin
          ref_mem[word][32*half + 8*i +: 8] = data[8*i +: 8];
        end
      end
    end
    return rsp;
  endfunction

  // Handshakes are taken late in the cycle while the DUT outputs are settled
  always begin
    @(negedge clock);
    #40;
    a_taken = a_valid_i && a_ready_o;
    d_taken = d_valid_o && d_ready_i;
  end

  // Track accepted requests in order, the oldest one is the next D beat
  always @(posedge clock) begin
    if (rst_n_i) begin
      if (d_taken && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (a_taken) begin
        exp_q.push_back(model_request(a_opcode_i, a_size_i, a_source_i, a_address_i,
                                      a_mask_i, a_data_i));
      end
      pending <= exp_q.size();
      if (exp_q.size() > 0) begin
        head <= exp_q[0];
      end
    end
  end

  d_opcode_ok: assert property (@(posedge clock) disable iff (!rst_n_i)
    (d_valid_o && d_ready_i && pending > 0) |-> d_opcode_o == head.op)
    else begin
      mismatches++;
      $display("mismatch at %0t: d_opcode_o %0d, expected %0d", $time,
               $sampled(d_opcode_o), $sampled(head.op));
    end

  d_size_ok: assert property (@(posedge clock) disable iff (!rst_n_i)
    (d_valid_o && d_ready_i && pending > 0) |-> d_size_o == head.size)
    else begin
      mismatches++;
      $display("mismatch at %0t: d_size_o %0d, expected %0d", $time,
               $sampled(d_size_o), $sampled(head.size));
    end

  // Sources come back in request order
  d_source_ok: assert property (@(posedge clock) disable iff (!rst_n_i)
    (d_valid_o && d_ready_i && pending > 0) |-> d_source_o == head.source)
    else begin
      mismatches++;
      $display("mismatch at %0t: d_source_o %h, expected %h", $time,
               $sampled(d_source_o), $sampled(head.source));
    end

  d_data_ok: assert property (@(posedge clock) disable iff (!rst_n_i)
    (d_valid_o && d_ready_i && pending > 0) |-> d_data_o == head.data)
    else begin
      mismatches++;
      $display("mismatch at %0t: d_data_o %h, expected %h", $time,
               $sampled(d_data_o), $sampled(head.data));
    end

  d_error_ok: assert property (@(posedge clock) disable iff (!rst_n_i)
    (d_valid_o && d_ready_i && pending > 0) |-> d_error_o == head.error)
    else begin
      mismatches++;
      $display("mismatch at %0t: d_error_o %b, expected %b", $time,
               $sampled(d_error_o), $sampled(head.error));
    end

  d_has_request: assert property (@(posedge clock) disable iff (!rst_n_i)
    d_valid_o |-> pending > 0)
    else begin
      other_errors++;
      $display("D response at %0t without any request outstanding", $time);
    end

  // A stalled response keeps every field until it is taken
  d_held: assert property (@(posedge clock) disable iff (!rst_n_i)
    (d_valid_o && !d_ready_i) |=> (d_valid_o && $stable(d_opcode_o) && $stable(d_size_o) &&
      $stable(d_source_o) && $stable(d_data_o) && $stable(d_error_o)))
    else begin
      other_errors++;
      $display("D response at %0t changed or dropped while d_ready_i was low", $time);
    end

  depth_limit: assert property (@(posedge clock) disable iff (!rst_n_i)
    pending <= `OUTSTANDING_DEF)
    else begin
      other_errors++;
      $display("More than %0d requests accepted at %0t", `OUTSTANDING_DEF, $time);
    end

  full_stalls: assert property (@(posedge clock) disable iff (!rst_n_i)
    pending >= `OUTSTANDING_DEF |-> !a_ready_o)
    else begin
      other_errors++;
      $display("a_ready_o high at %0t with all slots in use", $time);
    end

  task automatic report_and_finish();
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // Present one request on the falling edge and hold it until it is taken
  task automatic send(input logic [2:0] op, input logic [`TL_SZW-1:0] size,
                      input logic [`TL_AW-1:0] addr, input logic [`TL_DBW-1:0] mask,
                      input logic [`TL_DW-1:0] data);
    logic [31:0] r;
    logic        accepted;
    @(negedge clock);
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_size_i    = size;
    a_source_i  = source_id;
    a_address_i = addr;
    a_mask_i    = mask;
    a_data_i    = data;
    source_id   = source_id + 8'd1;
    accepted    = 1'b0;
    while (!accepted) begin
      if (random_ready) begin
        r = rand_bits(1);
        d_ready_i = r[0];
      end
      // a_ready_o has settled well before the next rising edge
      #10;
      accepted = a_ready_o;
      @(posedge clock);
      if (!accepted) begin
        @(negedge clock);
      end
    end
  endtask

  task automatic drain();
    @(negedge clock);
    a_valid_i = 1'b0;
    d_ready_i = 1'b1;
    while (pending != 0) begin
      @(negedge clock);
    end
  endtask

  // Mostly legal traffic inside the preloaded words, one pick in eight is arbitrary
  task automatic random_request();
    logic [31:0]        r;
    logic [2:0]         sel;
    logic [2:0]         op;
    logic [`TL_SZW-1:0] size;
    logic [`TL_AW-1:0]  addr;
    logic [`TL_DBW-1:0] mask;
    sel  = 3'(rand_bits(3));
    size = 2'(rand_bits(2) % 3);
    addr = rand_bits(6) & ~((32'd1 << size) - 32'd1);
    mask = covered_lanes(int'(addr[1:0]), int'(size));
    op   = Get;
    case (sel)
      3'd0, 3'd1, 3'd2: op = Get;
      3'd3, 3'd4:       op = PutFullData;
      3'd5, 3'd6: begin
        op   = PutPartialData;
        r    = rand_bits(4);
        mask = mask & r[3:0];
      end
      default: begin
        op   = 3'(rand_bits(3));
        size = 2'(rand_bits(2));
        addr = rand_bits(6);
        mask = 4'(rand_bits(4));
      end
    endcase
    send(op, size, addr, mask, rand_bits(32));
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    other_errors++;
    $display("Timeout, the test did not finish within %0d cycles", CYCLE_LIMIT);
    report_and_finish();
  end

  initial begin
    clock        = 1'b0;
    rst_n_i      = 1'b0;
    a_valid_i    = 1'b0;
    a_opcode_i   = 3'h0;
    a_size_i     = '0;
    a_source_i   = '0;
    a_address_i  = '0;
    a_mask_i     = '0;
    a_data_i     = '0;
    d_ready_i    = 1'b0;
    lfsr         = 32'hf719a454;
    source_id    = '0;
    random_ready = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    repeat (2) @(negedge clock);
    rst_n_i   = 1'b1;
    d_ready_i = 1'b1;
    @(negedge clock);
    assert (a_ready_o && !d_valid_o) else begin
      other_errors++;
      $display("After reset a_ready_o is not high or d_valid_o is not low");
    end

    // Full word write then read back
    send(PutFullData, 2'd2, 32'h40, 4'hf, rand_bits(32));
    send(Get, 2'd2, 32'h40, 4'hf, 32'h0);
    drain();

    // Partial writes into both halves of one SRAM word
    send(PutFullData, 2'd2, 32'h50, 4'hf, rand_bits(32));
    send(PutFullData, 2'd2, 32'h54, 4'hf, rand_bits(32));
    send(PutPartialData, 2'd0, 32'h51, 4'b0010, rand_bits(32));
    send(PutPartialData, 2'd1, 32'h56, 4'b1100, rand_bits(32));
    send(PutPartialData, 2'd2, 32'h50, 4'b1001, rand_bits(32));
    send(Get, 2'd2, 32'h50, 4'hf, 32'h0);
    send(Get, 2'd2, 32'h54, 4'hf, 32'h0);
    send(Get, 2'd0, 32'h53, 4'b1000, 32'h0);
    send(Get, 2'd1, 32'h56, 4'b1100, 32'h0);
    drain();

    // Unwritten word reports an error until something is written to it
    send(Get, 2'd2, 32'h80, 4'hf, 32'h0);
    send(PutPartialData, 2'd0, 32'h84, 4'b0001, rand_bits(32));
    send(Get, 2'd0, 32'h84, 4'b0001, 32'h0);
    drain();

    // Illegal requests, then check that the target word did not change
    send(3'h2, 2'd2, 32'h50, 4'hf, rand_bits(32));
    send(PutFullData, 2'd3, 32'h50, 4'hf, rand_bits(32));
    send(PutFullData, 2'd2, 32'h52, 4'hf, rand_bits(32));
    send(PutFullData, 2'd1, 32'h50, 4'hf, rand_bits(32));
    send(Get, 2'd0, 32'h51, 4'b0011, 32'h0);
    send(Get, 2'd3, 32'h50, 4'hf, 32'h0);
    send(Get, 2'd2, 32'h50, 4'hf, 32'h0);
    send(Get, 2'd2, 32'h54, 4'hf, 32'h0);
    drain();

    // D back-pressure, the third request has to wait for a free slot
    d_ready_i = 1'b0;
    fork
      begin
        send(Get, 2'd2, 32'h40, 4'hf, 32'h0);
        send(PutFullData, 2'd2, 32'h44, 4'hf, rand_bits(32));
        send(Get, 2'd2, 32'h44, 4'hf, 32'h0);
      end
      begin
        repeat (8) @(negedge clock);
        d_ready_i = 1'b1;
      end
    join
    drain();

    // Preload words 0 to 7 so random reads never see undefined bytes
    for (int i = 0; i < 16; i++) begin
      send(PutFullData, 2'd2, 32'(4 * i), 4'hf, rand_bits(32));
    end
    random_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      random_request();
    end
    random_ready = 1'b0;
    drain();

    report_and_finish();
  end

endmodule

// ==== tb.f ====
+incdir+.
tlul_pkg.sv
sram_pkg.sv
fifo_sync.sv
tlul_err.sv
tlul_sram_adapter.sv
sram_mem.sv
tlul_sram_top.sv
tb_tlul_sram.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench and the DUT with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module tb_tlul_sram -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
exit 1
